// File: sim.f
+incdir+verilog
verilog/edge_pe_pkg.sv
verilog/edge_pe_ifs.sv
verilog/neighbor_list.sv
verilog/fv_forward.sv
verilog/edge_pe_ctrl.sv
verilog/edge_pe.sv
tb/tb_edge_pe.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --top-module tb_edge_pe -f sim.f -o sim_edge_pe \
    && ./obj_dir/sim_edge_pe \
    || exit 1

// File: tb/tb_edge_pe.sv
`include "edge_pe_defines.svh"

module tb_edge_pe;

    localparam int NUM_TASKS       = 12;
    localparam int CYCLES_PER_TASK = 320; // 20 neighbors with slowest grants and streams
    localparam int WATCHDOG_TIME   = (NUM_TASKS * CYCLES_PER_TASK + 20) * 4;

    typedef struct packed {
        logic                  sos;
        logic                  eos;
        logic [`NODE_ID_W-1:0] node;
        logic [`FV_WIDTH-1:0]  data;
    } bank_beat_t;

    logic                       clk;
    logic                       reset;
    edge_pe_pkg::task_t         task_packet;
    logic                       task_valid;
    logic                       nbr_sos, nbr_eos;
    edge_pe_pkg::nbr_cnt_t      nbr_num;
    logic [`NBR_BEAT_W-1:0]     nbr_ids;
    logic                       fv_sos, fv_eos, out_sos, out_eos;
    logic [`FV_WIDTH-1:0]       fv_data, out_data;
    logic                       bus_grant, out_grant;
    logic [`REPLAY_W-1:0]       cur_replay_iter;
    logic                       bus_req, bus_req_type, out_req, out_grant_valid;
    logic [`NODE_ID_W-1:0]      bus_node_id, out_node_id, bank_node_id;
    logic                       bank_sos, bank_eos, done_aggr, idle;
    logic [`FV_LANE_W-1:0]      bank_lane0, bank_lane1, bank_lane2, bank_lane3;

    logic [31:0] lfsr;
    bank_beat_t  exp_q [$]; // filled by the stream driver
    logic        bank_open;

    edge_pe DUT (.*);

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // expected beat tagged by source node, beat index and lane
    function automatic logic [`FV_WIDTH-1:0] ref_beat(input logic [`NODE_ID_W-1:0] node,
                                                      input int beat, input bit prev);
        logic [`FV_WIDTH-1:0] v;
        for (int k = 0; k < `FV_LANES; k++)
            v[k*`FV_LANE_W +: `FV_LANE_W] = {prev ? 4'hb : 4'h3, 2'(k), 2'(beat), 1'b0, node};
        return v;
    endfunction

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("mismatch %s expected %0h actual %0h", name, exp, act);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    task automatic wait_request(input bit on_out);
        while (!(on_out ? out_req : bus_req)) begin
            check("done_aggr before request", 0, 64'(done_aggr));
            check("other request while waiting", 0, 64'(on_out ? bus_req : out_req));
            @(posedge clk);
        end
    endtask

    task automatic grant(input bit on_out, input int delay);
        repeat (delay) begin
            @(posedge clk);
            check("request held", 1, 64'(on_out ? out_req : bus_req));
        end
        if (on_out)
            out_grant <= 1'b1;
        else
            bus_grant <= 1'b1;
        @(posedge clk);
        check("request low in grant cycle", 0, 64'(on_out ? out_req : bus_req));
        if (on_out)
            check("out_grant_valid pulse", 1, 64'(out_grant_valid));
        bus_grant <= 1'b0;
        out_grant <= 1'b0;
    endtask

    task automatic send_stream(input bit prev, input logic [`NODE_ID_W-1:0] node,
                               input logic [`NODE_ID_W-1:0] target, input int len);
        bank_beat_t e;
        for (int b = 0; b < len; b++) begin
            e.sos  = (b == 0);
            e.eos  = (b == len - 1);
            e.node = target;
            e.data = ref_beat(node, b, prev);
            if (prev) begin
                out_sos  <= e.sos;
                out_eos  <= e.eos;
                out_data <= e.data;
            end else begin
                fv_sos  <= e.sos;
                fv_eos  <= e.eos;
                fv_data <= e.data;
            end
            exp_q.push_back(e);
            @(posedge clk);
        end
        fv_sos  <= 1'b0;
        fv_eos  <= 1'b0;
        out_sos <= 1'b0;
        out_eos <= 1'b0;
    endtask

    task automatic run_task(input int t);
        edge_pe_pkg::task_t     tp;
        logic [`NODE_ID_W-1:0]  nbrs [`MAX_DEGREE];
        logic [`NBR_BEAT_W-1:0] beat;
        logic [`REPLAY_W-1:0]   iter;
        int                     cnt;
        int                     nbeats;
        int                     idx;
        bit                     prev_exp;
        tp.iter_mask = `ITER_W'(rand_bits(`ITER_W));
        tp.prio      = `PRIO_W'(rand_bits(`PRIO_W));
        tp.target    = `NODE_ID_W'(rand_bits(`NODE_ID_W));
        iter         = `REPLAY_W'(rand_bits(`REPLAY_W));
        cnt          = int'(rand_bits(5) % 20) + 1;
        if (t == 0) begin // longest list with fetch forced on
            cnt          = 20;
            tp.iter_mask = '1;
            iter         = '1;
        end else if (t == 1) begin
            tp.iter_mask = '0;
        end
        for (int i = 0; i < cnt; i++)
            nbrs[i] = `NODE_ID_W'(rand_bits(`NODE_ID_W));
        prev_exp = |(tp.iter_mask & ((`ITER_W'(1) << iter) - `ITER_W'(1)));

        while (!idle)
            @(posedge clk);
        task_packet     <= tp;
        cur_replay_iter <= iter;
        task_valid      <= 1'b1;
        @(posedge clk);
        task_valid <= 1'b0;

        wait_request(1'b0);
        check("nbr request type", 64'(edge_pe_pkg::neighbor_id), 64'(bus_req_type));
        check("nbr request node", 64'(tp.target), 64'(bus_node_id));
        grant(1'b0, int'(rand_bits(2)));
        nbeats = (cnt + `IDS_PER_BEAT - 1) / `IDS_PER_BEAT;
        for (int b = 0; b < nbeats; b++) begin
            for (int j = 0; j < `IDS_PER_BEAT; j++) begin
                idx = b * `IDS_PER_BEAT + j;
                beat[j*`NODE_ID_W +: `NODE_ID_W] =
                    (idx < cnt) ? nbrs[idx] : `NODE_ID_W'(rand_bits(`NODE_ID_W));
            end
            nbr_sos <= (b == 0);
            nbr_eos <= (b == nbeats - 1);
            nbr_ids <= beat;
            nbr_num <= edge_pe_pkg::nbr_cnt_t'(cnt);
            @(posedge clk);
        end
        nbr_sos <= 1'b0;
        nbr_eos <= 1'b0;

        for (int i = 0; i < cnt; i++) begin
            wait_request(1'b0);
            check("feature request type", 64'(edge_pe_pkg::feature), 64'(bus_req_type));
            check("feature request node", 64'(nbrs[i]), 64'(bus_node_id));
            grant(1'b0, int'(rand_bits(2)));
            repeat (int'(rand_bits(1))) @(posedge clk);
            send_stream(1'b0, nbrs[i], tp.target, int'(rand_bits(2) % 3) + 1);
        end

        if (prev_exp) begin
            wait_request(1'b1);
            check("out request node", 64'(tp.target), 64'(out_node_id));
            grant(1'b1, int'(rand_bits(2)));
            send_stream(1'b1, tp.target, tp.target, int'(rand_bits(2) % 3) + 1);
        end

        while (!done_aggr) begin
            check("bus_req before done", 0, 64'(bus_req));
            check("out_req before done", 0, 64'(out_req | out_grant_valid));
            @(posedge clk);
        end
        check("bank strobes at done", 0, 64'({bank_sos, bank_eos}));
        check("bank beats outstanding at done", 0, 64'(exp_q.size()));
        check("done node", 64'(tp.target), 64'(bank_node_id));
        @(posedge clk);
        check("done pulse width", 0, 64'(done_aggr));
        while (!idle)
            @(posedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // bank beats in order against the queue
    always @(posedge clk) begin
        bank_beat_t e;
        if (reset && (bank_sos || bank_eos || bank_open)) begin
            check("bank beat expected", 1, 64'(exp_q.size() != 0));
            e = exp_q.pop_front();
            check("bank lanes", e.data, {bank_lane3, bank_lane2, bank_lane1, bank_lane0});
            check("bank sos", 64'(e.sos), 64'(bank_sos));
            check("bank eos", 64'(e.eos), 64'(bank_eos));
            check("bank node", 64'(e.node), 64'(bank_node_id));
            bank_open = !bank_eos;
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("timeout: the tasks did not finish in the expected time");
        $display("=== FAIL ===");
        $fatal(1);
    end

    initial begin
        lfsr            = 32'h8954;
        bank_open       = 1'b0;
        reset           = 1'b0;
        task_packet     = '0;
        task_valid      = 1'b0;
        nbr_sos         = 1'b0;
        nbr_eos         = 1'b0;
        nbr_num         = '0;
        nbr_ids         = '0;
        fv_sos          = 1'b0;
        fv_eos          = 1'b0;
        fv_data         = '0;
        out_sos         = 1'b0;
        out_eos         = 1'b0;
        out_data        = '0;
        bus_grant       = 1'b0;
        out_grant       = 1'b0;
        cur_replay_iter = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b1;
        @(posedge clk);
        @(posedge clk);
        check("idle after reset", 1, 64'(idle));
        check("outputs low after reset", 0,
              64'({bus_req, out_req, out_grant_valid, bank_sos, bank_eos, done_aggr}));
        for (int t = 0; t < NUM_TASKS; t++)
            run_task(t);
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: verilog/edge_pe.sv
`include "edge_pe_defines.svh"

module edge_pe (
    input  logic                                   clk,
    input  logic                                   reset,

    // dispatch
    input  logic [`ITER_W+`PRIO_W+`NODE_ID_W-1:0]  task_packet,
    input  logic                                   task_valid,

    // neighbor sram stream
    input  logic                                   nbr_sos,
    input  logic                                   nbr_eos,
    input  logic [$clog2(`MAX_DEGREE)-1:0]         nbr_num,
    input  logic [`NBR_BEAT_W-1:0]                 nbr_ids,

    // feature sram stream
    input  logic                                   fv_sos,
    input  logic                                   fv_eos,
    input  logic [`FV_WIDTH-1:0]                   fv_data,

    // output sram stream, previous iteration
    input  logic                                   out_sos,
    input  logic                                   out_eos,
    input  logic [`FV_WIDTH-1:0]                   out_data,

    input  logic                                   bus_grant,
    input  logic                                   out_grant,
    input  logic [`REPLAY_W-1:0]                   cur_replay_iter,

    output logic                                   bus_req,
    output logic                                   bus_req_type,
    output logic [`NODE_ID_W-1:0]                  bus_node_id,

    output logic                                   out_req,
    output logic                                   out_grant_valid,
    output logic [`NODE_ID_W-1:0]                  out_node_id,

    // aggregation bank
    output logic                                   bank_sos,
    output logic                                   bank_eos,
    output logic [`FV_LANE_W-1:0]                  bank_lane0,
    output logic [`FV_LANE_W-1:0]                  bank_lane1,
    output logic [`FV_LANE_W-1:0]                  bank_lane2,
    output logic [`FV_LANE_W-1:0]                  bank_lane3,
    output logic [`NODE_ID_W-1:0]                  bank_node_id,
    output logic                                   done_aggr,

    output logic                                   idle
);

    nbr_if nbr ();
    fwd_if fwd ();

    edge_pe_ctrl u_ctrl (
        .clk             (clk),
        .reset           (reset),
        .task_packet     (task_packet),
        .task_valid      (task_valid),
        .bus_grant       (bus_grant),
        .out_grant       (out_grant),
        .cur_replay_iter (cur_replay_iter),
        .bus_req         (bus_req),
        .bus_req_type    (bus_req_type),
        .bus_node_id     (bus_node_id),
        .out_req         (out_req),
        .out_grant_valid (out_grant_valid),
        .out_node_id     (out_node_id),
        .done_aggr       (done_aggr),
        .idle            (idle),
        .nbr             (nbr.ctrl),
        .fwd             (fwd.ctrl)
    );

    neighbor_list u_nbr_list (
        .clk     (clk),
        .reset   (reset),
        .nbr_sos (nbr_sos),
        .nbr_eos (nbr_eos),
        .nbr_num (nbr_num),
        .nbr_ids (nbr_ids),
        .nbr     (nbr.list)
    );

    fv_forward u_fv_fwd (
        .clk          (clk),
        .reset        (reset),
        .fv_sos       (fv_sos),
        .fv_eos       (fv_eos),
        .fv_data      (fv_data),
        .out_sos      (out_sos),
        .out_eos      (out_eos),
        .out_data     (out_data),
        .bank_sos     (bank_sos),
        .bank_eos     (bank_eos),
        .bank_lanes   ({bank_lane3, bank_lane2, bank_lane1, bank_lane0}), // lane 0 low
        .bank_node_id (bank_node_id),
        .fwd          (fwd.fwd)
    );

endmodule

// File: verilog/edge_pe_ctrl.sv
`include "edge_pe_defines.svh"

module edge_pe_ctrl (
    input  logic                    clk,
    input  logic                    reset,
    input  edge_pe_pkg::task_t      task_packet,
    input  logic                    task_valid,
    input  logic                    bus_grant,
    input  logic                    out_grant,
    input  logic [`REPLAY_W-1:0]    cur_replay_iter,
    output logic                    bus_req,
    output edge_pe_pkg::req_type_t  bus_req_type,
    output edge_pe_pkg::node_id_t   bus_node_id,
    output logic                    out_req,
    output logic                    out_grant_valid,
    output edge_pe_pkg::node_id_t   out_node_id,
    output logic                    done_aggr,
    output logic                    idle,
    nbr_if.ctrl                     nbr,
    fwd_if.ctrl                     fwd
);

    edge_pe_pkg::state_t   state;
    edge_pe_pkg::state_t   nx_state;
    edge_pe_pkg::task_t    task_q;
    edge_pe_pkg::nbr_cnt_t req_ptr; // feature requests granted so far
    logic                  fetch_prev;
    logic                  in_bus_req;
    logic                  in_fv_req;

    // previous output is needed if an earlier iteration is masked in
    always_comb begin
        fetch_prev = 1'b0;
        for (int i = 0; i < `ITER_W; i++) begin
            if (i < int'(cur_replay_iter) && task_q.iter_mask[i])
                fetch_prev = 1'b1;
        end
    end

    always_comb begin
        nx_state = state;
        case (state)
            edge_pe_pkg::idle: begin
                if (task_valid)
                    nx_state = edge_pe_pkg::req_nbr_id;
            end
            edge_pe_pkg::req_nbr_id: begin
                if (bus_grant)
                    nx_state = edge_pe_pkg::recv_nbr_id;
            end
            edge_pe_pkg::recv_nbr_id: begin
                if (nbr.list_done)
                    nx_state = edge_pe_pkg::req_nbr_fv;
            end
            edge_pe_pkg::req_nbr_fv: begin
                if (bus_grant)
                    nx_state = edge_pe_pkg::recv_nbr_fv;
            end
            edge_pe_pkg::recv_nbr_fv: begin
                if (fwd.stream_end) begin
                    if (req_ptr != nbr.count)
                        nx_state = edge_pe_pkg::req_nbr_fv;
                    else if (fetch_prev)
                        nx_state = edge_pe_pkg::req_prev_out;
                    else
                        nx_state = edge_pe_pkg::complete;
                end
            end
            edge_pe_pkg::req_prev_out: begin
                if (out_grant)
                    nx_state = edge_pe_pkg::recv_prev_out;
            end
            edge_pe_pkg::recv_prev_out: begin
                if (fwd.stream_end)
                    nx_state = edge_pe_pkg::complete;
            end
            edge_pe_pkg::complete: nx_state = edge_pe_pkg::idle;
            default:               nx_state = edge_pe_pkg::idle;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state     <= edge_pe_pkg::idle;
            req_ptr   <= '0;
            done_aggr <= 1'b0;
            idle      <= 1'b0;
        end else begin
            state     <= nx_state;
            done_aggr <= (state == edge_pe_pkg::complete);
            idle      <= (state == edge_pe_pkg::idle) && !task_valid;
            if (state == edge_pe_pkg::recv_nbr_id)
                req_ptr <= '0;
            else if (in_fv_req && bus_grant)
                req_ptr <= req_ptr + 1'b1;
        end
    end

    // task fields held for the whole task
    always_ff @(posedge clk) begin
        if (state == edge_pe_pkg::idle && task_valid)
            task_q <= task_packet;
    end

    assign in_fv_req  = (state == edge_pe_pkg::req_nbr_fv);
    assign in_bus_req = (state == edge_pe_pkg::req_nbr_id) || in_fv_req;

    // request levels drop on the grant cycle
    assign bus_req      = in_bus_req && !bus_grant;
    assign bus_req_type = in_fv_req ? edge_pe_pkg::feature : edge_pe_pkg::neighbor_id;
    assign bus_node_id  = in_fv_req ? nbr.rd_id : task_q.target;

    assign out_req         = (state == edge_pe_pkg::req_prev_out) && !out_grant;
    assign out_grant_valid = (state == edge_pe_pkg::req_prev_out) && out_grant;
    assign out_node_id     = task_q.target;

    assign nbr.capture = (state == edge_pe_pkg::recv_nbr_id);
    assign nbr.rd_idx  = req_ptr;

    assign fwd.active  = (state == edge_pe_pkg::recv_nbr_fv) ||
                         (state == edge_pe_pkg::recv_prev_out);
    assign fwd.src_sel = (state == edge_pe_pkg::recv_prev_out);
    assign fwd.node_id = task_q.target;

endmodule

// File: verilog/fv_forward.sv
`include "edge_pe_defines.svh"

module fv_forward (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   fv_sos,
    input  logic                   fv_eos,
    input  logic [`FV_WIDTH-1:0]   fv_data,
    input  logic                   out_sos,
    input  logic                   out_eos,
    input  logic [`FV_WIDTH-1:0]   out_data,
    output logic                   bank_sos,
    output logic                   bank_eos,
    output edge_pe_pkg::fv_beat_t  bank_lanes,
    output edge_pe_pkg::node_id_t  bank_node_id,
    fwd_if.fwd                     fwd
);

    logic                 sel_sos;
    logic                 sel_eos;
    logic [`FV_WIDTH-1:0] sel_data;
    logic                 open;
    logic                 beat_en;

    assign sel_sos  = fwd.src_sel ? out_sos  : fv_sos;
    assign sel_eos  = fwd.src_sel ? out_eos  : fv_eos;
    assign sel_data = fwd.src_sel ? out_data : fv_data;

    assign beat_en = fwd.active && (sel_sos || sel_eos || open);
    assign fwd.stream_end = fwd.active && sel_eos;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            open     <= 1'b0;
            bank_sos <= 1'b0;
            bank_eos <= 1'b0;
        end else begin
            bank_sos <= fwd.active && sel_sos;
            bank_eos <= fwd.active && sel_eos;
            if (!fwd.active || sel_eos)
                open <= 1'b0;
            else if (sel_sos)
                open <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_en) begin
            bank_lanes   <= edge_pe_pkg::fv_beat_t'(sel_data); // split into 16-bit lanes
            bank_node_id <= fwd.node_id;
        end
    end

endmodule

// File: verilog/neighbor_list.sv
`include "edge_pe_defines.svh"

module neighbor_list (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    nbr_sos,
    input  logic                    nbr_eos,
    input  edge_pe_pkg::nbr_cnt_t   nbr_num,
    input  logic [`NBR_BEAT_W-1:0]  nbr_ids,
    nbr_if.list                     nbr
);

    edge_pe_pkg::node_id_t ids [`MAX_DEGREE];
    edge_pe_pkg::nbr_cnt_t wr_off;
    logic                  in_stream;
    logic                  beat_en;

    assign beat_en = nbr.capture && (nbr_sos || nbr_eos || in_stream);
    assign nbr.list_done = nbr.capture && nbr_eos;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            in_stream <= 1'b0;
            wr_off    <= '0;
            nbr.count <= '0;
        end else if (beat_en) begin
            if (nbr_eos) begin
                in_stream <= 1'b0;
                wr_off    <= '0;
                nbr.count <= nbr_num; // total arrives with the last beat
            end else begin
                in_stream <= 1'b1;
                wr_off    <= wr_off + 6'(`IDS_PER_BEAT);
            end
        end
    end

    // nine ids per beat, packed from the low end
    always_ff @(posedge clk) begin
        if (beat_en) begin
            for (int i = 0; i < `IDS_PER_BEAT; i++) begin
                if (int'(wr_off) + i < `MAX_DEGREE)
                    ids[int'(wr_off) + i] <= nbr_ids[i*`NODE_ID_W +: `NODE_ID_W];
            end
        end
    end

    always_comb begin
        if (int'(nbr.rd_idx) < `MAX_DEGREE)
            nbr.rd_id = ids[nbr.rd_idx];
        else
            nbr.rd_id = '0;
    end

endmodule

// File: verilog/edge_pe_ifs.sv
// controller to neighbor list
interface nbr_if;
    logic                  capture;
    edge_pe_pkg::nbr_cnt_t rd_idx;
    logic                  list_done;
    edge_pe_pkg::nbr_cnt_t count;
    edge_pe_pkg::node_id_t rd_id;

    modport ctrl (
        output capture,
        output rd_idx,
        input  list_done,
        input  count,
        input  rd_id
    );

    modport list (
        input  capture,
        input  rd_idx,
        output list_done,
        output count,
        output rd_id
    );
endinterface

// controller to feature forwarder
interface fwd_if;
    logic                  active;
    logic                  src_sel; // 0 feature sram, 1 output sram
    edge_pe_pkg::node_id_t node_id;
    logic                  stream_end;

    modport ctrl (
        output active,
        output src_sel,
        output node_id,
        input  stream_end
    );

    modport fwd (
        input  active,
        input  src_sel,
        input  node_id,
        output stream_end
    );
endinterface

// File: verilog/edge_pe_pkg.sv
`include "edge_pe_defines.svh"

package edge_pe_pkg;

    typedef logic [`NODE_ID_W-1:0] node_id_t;

    // count and index into the stored list
    typedef logic [$clog2(`MAX_DEGREE)-1:0] nbr_cnt_t;

    typedef logic [`FV_LANE_W-1:0] fv_lane_t;

    typedef fv_lane_t [`FV_LANES-1:0] fv_beat_t; // lane 0 in the low bits

    typedef struct packed {
        logic [`ITER_W-1:0] iter_mask;
        logic [`PRIO_W-1:0] prio;
        node_id_t           target;
    } task_t;

    typedef enum logic {
        neighbor_id = 1'b0,
        feature     = 1'b1
    } req_type_t;

    typedef enum logic [3:0] {
        idle          = 4'd0,
        req_nbr_id    = 4'd1,
        recv_nbr_id   = 4'd2,
        req_nbr_fv    = 4'd3,
        recv_nbr_fv   = 4'd4,
        req_prev_out  = 4'd5,
        recv_prev_out = 4'd6,
        complete      = 4'd7,
        wb_req        = 4'd8, // write-back, not built
        fence_gen     = 4'd9  // spare
    } state_t;

endpackage

// File: verilog/edge_pe_defines.svh
`ifndef EDGE_PE_DEFINES_SVH
`define EDGE_PE_DEFINES_SVH

// feature path
`define FV_WIDTH     64
`define FV_LANES     4
`define FV_LANE_W    16

// neighbor path
`define NODE_ID_W    7
`define IDS_PER_BEAT 9
`define NBR_BEAT_W   63
`define MAX_DEGREE   36

// task fields
`define ITER_W       4
`define REPLAY_W     2
`define PRIO_W       3

`endif
